// File: list.f
hdl/host_chan_pkg.sv
hdl/host_chan_ctrl_if.sv
hdl/tlp_fifo.sv
hdl/host_chan_csr.sv
hdl/host_chan_tx_arb.sv
hdl/host_chan_rx_route.sv
hdl/host_chan_top.sv
test/tb_host_chan.sv

// File: Makefile
SIM      = verilator
TOP      = tb_host_chan
FILELIST = list.f
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
BIN      = obj_dir/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: run clean

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_host_chan.sv
/*
 * Testbench for the emulated host channel: register access, TX merge
 * and stamping, TX back-pressure, RX routing, drops and counters
 */
`default_nettype none

module tb_host_chan;

    import host_chan_pkg::*;

    localparam int NUM_PORTS = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int TX_PKTS = 8;
    localparam int RX_PKTS = 24;
    localparam int MAX_LEN = 4;
    localparam int WATCHDOG_CYCLES = (TX_PKTS * NUM_PORTS + RX_PKTS) * MAX_LEN * NUM_PORTS * 4;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic [NUM_PORTS-1:0] afu_tx_valid;
    logic [NUM_PORTS-1:0] afu_tx_ready;
    t_afu_beat afu_tx_data [NUM_PORTS];
    logic host_tx_valid;
    logic host_tx_ready;
    t_tlp_beat host_tx_data;
    logic host_rx_valid;
    logic host_rx_ready;
    t_tlp_beat host_rx_data;
    logic [NUM_PORTS-1:0] afu_rx_valid;
    logic [NUM_PORTS-1:0] afu_rx_ready;
    t_afu_beat afu_rx_data;
    logic soft_reset;
    logic [1:0] pwr_state;

    // Scoreboard, filled by the stimulus and emptied as beats leave the DUT
    t_afu_beat tx_exp [NUM_PORTS][$];
    t_afu_beat rx_exp [NUM_PORTS][$];
    int tx_sent [NUM_PORTS];
    int rx_drops;

    // Register model and the value the current APB read must return
    logic exp_soft;
    logic [1:0] exp_pwr;
    logic [31:0] exp_rdata;

    // Handshake history, registered at posedge and consumed at negedge
    logic [NUM_PORTS-1:0] tx_acc;
    logic rx_acc;
    logic tx_pop;
    logic [FUNC_WIDTH-1:0] tx_pop_func;
    logic [NUM_PORTS-1:0] rx_pop;
    logic tx_open;
    logic [FUNC_WIDTH-1:0] tx_open_func;
    logic [31:0] lcg_state;
    logic [31:0] ready_rand;
    logic host_xfer;

    host_chan_top #(.NUM_PORTS(NUM_PORTS), .FIFO_DEPTH(FIFO_DEPTH)) i_dut
       (
        .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .afu_tx_valid, .afu_tx_ready, .afu_tx_data,
        .host_tx_valid, .host_tx_ready, .host_tx_data,
        .host_rx_valid, .host_rx_ready, .host_rx_data,
        .afu_rx_valid, .afu_rx_ready, .afu_rx_data,
        .soft_reset, .pwr_state
        );

    task automatic stop_failed();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic value_error(string sig, logic [63:0] exp, logic [63:0] got);
        $display("[ERROR] %0t %s expected %h got %h", $time, sig, exp, got);
        stop_failed();
    endtask

    task automatic run_error(string msg);
        $display("[ERROR] %0t %s", $time, msg);
        stop_failed();
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic t_afu_beat tx_head(logic [FUNC_WIDTH-1:0] f);
        if (f >= NUM_PORTS || tx_exp[f].size() == 0)
            return '1;
        return tx_exp[f][0];
    endfunction

    // Expected RX head for the lowest port that is raising valid
    function automatic t_afu_beat rx_head(logic [NUM_PORTS-1:0] vec);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (vec[p] && rx_exp[p].size() != 0)
                return rx_exp[p][0];
        end
        return '1;
    endfunction

    function automatic bit rx_pending(logic [NUM_PORTS-1:0] vec);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (vec[p] && rx_exp[p].size() == 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic bit queues_empty();
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (tx_exp[p].size() != 0 || rx_exp[p].size() != 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign host_xfer = host_tx_valid && host_tx_ready;

    always @(posedge clk)
    begin
        tx_acc <= afu_tx_valid & afu_tx_ready;
        rx_acc <= host_rx_valid && host_rx_ready;
        tx_pop <= host_xfer;
        tx_pop_func <= host_tx_data.func_num;
        rx_pop <= afu_rx_valid & afu_rx_ready;
        if (reset)
            tx_open <= 1'b0;
        else if (host_xfer)
        begin
            tx_open <= !host_tx_data.beat.eop;
            tx_open_func <= host_tx_data.func_num;
        end
    end

    // Retire the beats that left the DUT on the last rising edge
    always @(negedge clk)
    begin
        if (tx_pop && tx_pop_func < NUM_PORTS && tx_exp[tx_pop_func].size() != 0)
            void'(tx_exp[tx_pop_func].pop_front());
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (rx_pop[p] && rx_exp[p].size() != 0)
                void'(rx_exp[p].pop_front());
        end
    end

    // Random sink back-pressure, roughly three ready cycles in four
    always @(negedge clk)
    begin
        ready_rand = next_rand();
        host_tx_ready = (ready_rand[17:16] != 2'b00);
        afu_rx_ready = ready_rand[27:24] | ready_rand[23:20];
    end

    a_prdata: assert property (@(posedge clk) disable iff (reset)
        (psel && penable && !pwrite) |-> (prdata == exp_rdata))
        else value_error("prdata", exp_rdata, $sampled(prdata));

    a_soft_reset: assert property (@(posedge clk) disable iff (reset)
        soft_reset == exp_soft)
        else value_error("soft_reset", exp_soft, $sampled(soft_reset));

    a_pwr_state: assert property (@(posedge clk) disable iff (reset)
        pwr_state == exp_pwr)
        else value_error("pwr_state", exp_pwr, $sampled(pwr_state));

    a_tx_known: assert property (@(posedge clk) disable iff (reset)
        host_xfer |-> (host_tx_data.func_num < NUM_PORTS &&
                       tx_exp[host_tx_data.func_num].size() != 0))
        else run_error("host_tx beat carries a function number with nothing pending");

    // Data, sop and eop of each beat in order, which also catches duplicates
    a_tx_data: assert property (@(posedge clk) disable iff (reset)
        host_xfer |-> (host_tx_data.beat == tx_head(host_tx_data.func_num)))
        else value_error("host_tx_data.beat", tx_head($sampled(host_tx_data.func_num)),
                         $sampled(host_tx_data.beat));

    a_tx_atomic: assert property (@(posedge clk) disable iff (reset)
        (host_xfer && tx_open) |-> (host_tx_data.func_num == tx_open_func))
        else value_error("host_tx_data.func_num", tx_open_func,
                         $sampled(host_tx_data.func_num));

    // Any stalled beat, first beats included, must hold on the host stream
    a_tx_stall: assert property (@(posedge clk) disable iff (reset)
        (host_tx_valid && !host_tx_ready) |=>
        (host_tx_valid && $stable(host_tx_data)))
        else run_error("host_tx_data changed while stalled by host_tx_ready");

    a_rx_known: assert property (@(posedge clk) disable iff (reset)
        (afu_rx_valid != '0) |-> rx_pending(afu_rx_valid))
        else run_error("afu_rx_valid raised for a port with no packet expected");

    a_rx_data: assert property (@(posedge clk) disable iff (reset)
        ((afu_rx_valid & afu_rx_ready) != '0) |-> (afu_rx_data == rx_head(afu_rx_valid)))
        else value_error("afu_rx_data", rx_head($sampled(afu_rx_valid)), $sampled(afu_rx_data));

    task automatic apb_write(logic [7:0] addr, logic [31:0] data);
        @(negedge clk);
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        // The write has landed by now, so the model follows it
        if (addr == REG_CTRL)
            exp_soft = data[0];
        if (addr == REG_PWR)
            exp_pwr = data[1:0];
    endtask

    task automatic apb_read(logic [7:0] addr, logic [31:0] exp);
        @(negedge clk);
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        exp_rdata = exp;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // Called at a negedge; returns at the negedge after the last beat went in
    task automatic send_tx_pkt(int p, int len);
        t_afu_beat b;
        for (int i = 0; i < len; i++)
        begin
            b.data = next_rand();
            b.sop = (i == 0);
            b.eop = (i == len - 1);
            afu_tx_data[p] = b;
            afu_tx_valid[p] = 1'b1;
            tx_exp[p].push_back(b);
            do @(negedge clk); while (!tx_acc[p]);
        end
        afu_tx_valid[p] = 1'b0;
        tx_sent[p]++;
    endtask

    task automatic run_port(int p);
        @(negedge clk);
        for (int k = 0; k < TX_PKTS; k++)
        begin
            send_tx_pkt(p, 1 + int'(next_rand() % MAX_LEN));
            repeat (int'(next_rand() % 3)) @(negedge clk);
        end
    endtask

    // Ports 0 to 2 enabled, so port 3 and function 7 are dropped
    task automatic send_rx_pkt(logic [FUNC_WIDTH-1:0] f, int len);
        t_tlp_beat b;
        if (f >= 3)
            rx_drops++;
        for (int i = 0; i < len; i++)
        begin
            b.func_num = f;
            b.beat.data = next_rand();
            b.beat.sop = (i == 0);
            b.beat.eop = (i == len - 1);
            host_rx_data = b;
            host_rx_valid = 1'b1;
            if (f < 3)
                rx_exp[f].push_back(b.beat);
            do @(negedge clk); while (!rx_acc);
        end
        host_rx_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (!queues_empty())
            @(negedge clk);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        run_error("watchdog expired before the tests completed");
    end

    initial
    begin
        logic [FUNC_WIDTH-1:0] f;
        lcg_state = 32'd86925;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        afu_tx_valid = '0;
        afu_tx_data = '{default: '0};
        host_tx_ready = 1'b0;
        host_rx_valid = 1'b0;
        host_rx_data = '0;
        afu_rx_ready = '0;
        rx_drops = 0;
        tx_sent = '{default: 0};
        exp_soft = 1'b1;
        exp_pwr = 2'b00;
        exp_rdata = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset values, then write and read back
        apb_read(REG_CTRL, 32'd1);
        apb_read(REG_PWR, 32'd0);
        apb_read(REG_PORT_EN, 32'd0);
        apb_write(REG_CTRL, 32'd0);
        apb_write(REG_PWR, 32'd2);
        apb_write(REG_PORT_EN, 32'hF);
        apb_read(REG_CTRL, 32'd0);
        apb_read(REG_PWR, 32'd2);
        apb_read(REG_PORT_EN, 32'hF);

        // All ports transmit at once into the arbiter
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            automatic int q = p;
            fork
                run_port(q);
            join_none
        end
        wait fork;
        wait_drained();
        for (int p = 0; p < NUM_PORTS; p++)
            apb_read(REG_TX_CNT_BASE + 8'(4 * p), tx_sent[p]);

        apb_write(REG_PORT_EN, 32'h7);
        @(negedge clk);
        for (int k = 0; k < RX_PKTS; k++)
        begin
            f = FUNC_WIDTH'(next_rand() % 5);
            if (f == 4)
                f = 4'd7;
            // A delivered last packet proves every earlier drop was consumed
            if (k == RX_PKTS - 1)
                f = 4'd0;
            send_rx_pkt(f, 1 + int'(next_rand() % MAX_LEN));
        end
        wait_drained();
        apb_read(REG_RX_DROP, rx_drops);
        repeat (2) @(negedge clk);

        if (queues_empty())
        begin
            $display("*** PASSED ***");
            $finish;
        end
        else
        begin
            run_error("scoreboard still holds beats at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: hdl/host_chan_top.sv
/*
 * Emulated host channel top: per-port TX FIFOs, the TX arbiter, the
 * host RX FIFO and router, and the APB management registers
 */
`default_nettype none

module host_chan_top
  #(
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 4
    )
   (
    input  wire                       clk,
    input  wire                       reset,

    // APB management port
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire  [7:0]                paddr,
    input  wire  [31:0]               pwdata,
    output logic [31:0]               prdata,

    // Accelerator TX streams
    input  wire  [NUM_PORTS-1:0]      afu_tx_valid,
    output logic [NUM_PORTS-1:0]      afu_tx_ready,
    input  wire  host_chan_pkg::t_afu_beat afu_tx_data [NUM_PORTS],

    // Merged host TX stream
    output logic                      host_tx_valid,
    input  wire                       host_tx_ready,
    output host_chan_pkg::t_tlp_beat  host_tx_data,

    // Host RX stream
    input  wire                       host_rx_valid,
    output logic                      host_rx_ready,
    input  wire  host_chan_pkg::t_tlp_beat host_rx_data,

    // Accelerator RX streams share one data bus
    output logic [NUM_PORTS-1:0]      afu_rx_valid,
    input  wire  [NUM_PORTS-1:0]      afu_rx_ready,
    output host_chan_pkg::t_afu_beat  afu_rx_data,

    output logic                      soft_reset,
    output logic [1:0]                pwr_state
    );

    import host_chan_pkg::*;

    logic [NUM_PORTS-1:0] tx_fifo_valid;
    logic [NUM_PORTS-1:0] tx_fifo_ready;
    t_afu_beat tx_fifo_data [NUM_PORTS];

    logic rx_fifo_valid;
    logic rx_fifo_ready;
    t_tlp_beat rx_fifo_data;

    host_chan_ctrl_if #(.NUM_PORTS(NUM_PORTS)) ctrl ();

    // Each accelerator port gets its own buffer ahead of the arbiter
    genvar p;
    generate
        for (p = 0; p < NUM_PORTS; p = p + 1)
        begin : g_tx_fifo
            tlp_fifo
              #(
                .FIFO_DEPTH(FIFO_DEPTH),
                .t_payload(t_afu_beat)
                )
              i_tx_fifo
               (
                .clk,
                .reset,
                .in_valid(afu_tx_valid[p]),
                .in_ready(afu_tx_ready[p]),
                .in_data(afu_tx_data[p]),
                .out_valid(tx_fifo_valid[p]),
                .out_ready(tx_fifo_ready[p]),
                .out_data(tx_fifo_data[p])
                );
        end
    endgenerate

    host_chan_tx_arb #(.NUM_PORTS(NUM_PORTS)) i_tx_arb
       (
        .clk,
        .reset,
        .port_valid(tx_fifo_valid),
        .port_ready(tx_fifo_ready),
        .port_data(tx_fifo_data),
        .host_tx_valid,
        .host_tx_ready,
        .host_tx_data,
        .ctrl(ctrl)
        );

    // The RX buffer gives the one-cycle host-to-port latency
    tlp_fifo
      #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .t_payload(t_tlp_beat)
        )
      i_rx_fifo
       (
        .clk,
        .reset,
        .in_valid(host_rx_valid),
        .in_ready(host_rx_ready),
        .in_data(host_rx_data),
        .out_valid(rx_fifo_valid),
        .out_ready(rx_fifo_ready),
        .out_data(rx_fifo_data)
        );

    host_chan_rx_route #(.NUM_PORTS(NUM_PORTS)) i_rx_route
       (
        .clk,
        .reset,
        .in_valid(rx_fifo_valid),
        .in_ready(rx_fifo_ready),
        .in_data(rx_fifo_data),
        .afu_rx_valid,
        .afu_rx_ready,
        .afu_rx_data,
        .ctrl(ctrl)
        );

    host_chan_csr #(.NUM_PORTS(NUM_PORTS)) i_csr
       (
        .clk,
        .reset,
        .psel,
        .penable,
        .pwrite,
        .paddr,
        .pwdata,
        .prdata,
        .soft_reset,
        .pwr_state,
        .ctrl(ctrl)
        );

endmodule

`default_nettype wire

// File: hdl/host_chan_rx_route.sv
/*
 * Steers host RX beats to the accelerator port named by func_num and
 * discards packets aimed at disabled or nonexistent ports
 */
`default_nettype none

module host_chan_rx_route
  #(
    parameter int NUM_PORTS = 4
    )
   (
    input  wire                       clk,
    input  wire                       reset,

    input  wire                       in_valid,
    output logic                      in_ready,
    input  wire  host_chan_pkg::t_tlp_beat in_data,

    output logic [NUM_PORTS-1:0]      afu_rx_valid,
    input  wire  [NUM_PORTS-1:0]      afu_rx_ready,
    output host_chan_pkg::t_afu_beat  afu_rx_data,

    host_chan_ctrl_if.rx ctrl
    );

    import host_chan_pkg::*;

    // The deliver-or-drop choice is taken at the first beat and kept to eop
    logic in_pkt;
    logic pkt_drop;
    logic hit;
    logic hit_ready;

    // All ports see the same data, only one valid bit is raised
    assign afu_rx_data = in_data.beat;

    always_comb
    begin
        afu_rx_valid = '0;
        hit = 1'b0;
        hit_ready = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if ((in_data.func_num == FUNC_WIDTH'(p)) &&
                (in_pkt ? !pkt_drop : ctrl.port_en[p]))
            begin
                hit = 1'b1;
                hit_ready = afu_rx_ready[p];
                afu_rx_valid[p] = in_valid;
            end
        end
    end

    // Beats with no live target are swallowed at full rate
    assign in_ready = hit ? hit_ready : 1'b1;

    assign ctrl.rx_drop = in_valid && in_ready && !hit && in_data.beat.eop;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            in_pkt <= 1'b0;
            pkt_drop <= 1'b0;
        end
        else if (in_valid && in_ready)
        begin
            in_pkt <= !in_data.beat.eop;
            pkt_drop <= !hit;
        end
    end

    // A stalled beat stays on the same port with the same data until taken
    a_rx_hold: assert property (@(posedge clk) disable iff (reset)
        ((afu_rx_valid & ~afu_rx_ready) != '0) |=>
        ($stable(afu_rx_valid) && $stable(afu_rx_data)));

endmodule

`default_nettype wire

// File: hdl/host_chan_tx_arb.sv
/*
 * Packet-atomic round-robin merge of the per-port TX FIFOs onto the
 * host stream, stamping each packet with its port as function number
 */
`default_nettype none

module host_chan_tx_arb
  #(
    parameter int NUM_PORTS = 4
    )
   (
    input  wire                       clk,
    input  wire                       reset,

    input  wire  [NUM_PORTS-1:0]      port_valid,
    output logic [NUM_PORTS-1:0]      port_ready,
    input  wire  host_chan_pkg::t_afu_beat port_data [NUM_PORTS],

    output logic                      host_tx_valid,
    input  wire                       host_tx_ready,
    output host_chan_pkg::t_tlp_beat  host_tx_data,

    host_chan_ctrl_if.tx ctrl
    );

    import host_chan_pkg::*;

    localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    // Last port served, or the port that owns the packet in flight
    logic [PORT_W-1:0] grant;
    logic locked;
    logic [PORT_W-1:0] pick;
    logic pick_found;
    logic [PORT_W-1:0] sel;
    logic xfer;

    // Search enabled ports with data, starting just after the last grant
    always_comb
    begin
        int idx;
        pick = grant;
        pick_found = 1'b0;
        for (int i = 1; i <= NUM_PORTS; i++)
        begin
            idx = (int'(grant) + i) % NUM_PORTS;
            if (!pick_found && port_valid[idx] && ctrl.port_en[idx])
            begin
                pick = PORT_W'(idx);
                pick_found = 1'b1;
            end
        end
    end

    // A locked packet ignores its enable so that it always completes
    assign sel = locked ? grant : pick;
    assign host_tx_valid = locked ? port_valid[grant] : pick_found;

    always_comb
    begin
        host_tx_data.beat = port_data[sel];
        host_tx_data.func_num = FUNC_WIDTH'(sel);
    end

    always_comb
    begin
        port_ready = '0;
        port_ready[sel] = host_tx_valid && host_tx_ready;
    end

    assign xfer = host_tx_valid && host_tx_ready;

    assign ctrl.tx_eop = xfer && host_tx_data.beat.eop;
    assign ctrl.tx_port = sel;

    // Reset points the grant at the last port so port 0 goes first
    // Any presented beat locks its port, so a stalled sop keeps the grant too
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            grant <= PORT_W'(NUM_PORTS - 1);
            locked <= 1'b0;
        end
        else if (host_tx_valid)
        begin
            grant <= sel;
            locked <= !(host_tx_ready && host_tx_data.beat.eop);
        end
    end

    // A stalled beat keeps its grant and its payload until the host takes it
    a_grant_held: assert property (@(posedge clk) disable iff (reset)
        (host_tx_valid && !host_tx_ready) |=> (host_tx_valid && $stable(host_tx_data)));

endmodule

`default_nettype wire

// File: hdl/host_chan_csr.sv
/*
 * APB management registers: soft reset, power state, port enables,
 * a saturating RX drop counter and per-port TX packet counters
 */
`default_nettype none

module host_chan_csr
  #(
    parameter int NUM_PORTS = 4
    )
   (
    input  wire         clk,
    input  wire         reset,

    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [7:0]  paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,

    output logic        soft_reset,
    output logic [1:0]  pwr_state,

    host_chan_ctrl_if.regs ctrl
    );

    import host_chan_pkg::*;

    logic [NUM_PORTS-1:0] port_en;
    logic [31:0] tx_cnt [NUM_PORTS];
    logic [31:0] drop_cnt;
    logic wr_en;

    // Writes land on the edge that closes the access phase
    assign wr_en = psel && penable && pwrite;

    assign ctrl.port_en = port_en;

    // Soft reset comes up asserted, the host clears it once set up
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            soft_reset <= 1'b1;
            pwr_state <= 2'b00;
            port_en <= '0;
        end
        else if (wr_en)
        begin
            case (paddr)
                REG_CTRL: soft_reset <= pwdata[0];
                REG_PWR: pwr_state <= pwdata[1:0];
                REG_PORT_EN: port_en <= pwdata[NUM_PORTS-1:0];
                default: ;
            endcase
        end
    end

    // Event counters stick at all ones rather than wrap
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int p = 0; p < NUM_PORTS; p++)
                tx_cnt[p] <= '0;
            drop_cnt <= '0;
        end
        else
        begin
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (ctrl.tx_eop && (ctrl.tx_port == p) && (tx_cnt[p] != '1))
                    tx_cnt[p] <= tx_cnt[p] + 1'b1;
            end
            if (ctrl.rx_drop && (drop_cnt != '1))
                drop_cnt <= drop_cnt + 1'b1;
        end
    end

    // Read data is decoded straight from the address, unmapped reads give 0
    always_comb
    begin
        prdata = '0;
        case (paddr)
            REG_CTRL: prdata[0] = soft_reset;
            REG_PWR: prdata[1:0] = pwr_state;
            REG_PORT_EN: prdata[NUM_PORTS-1:0] = port_en;
            REG_RX_DROP: prdata = drop_cnt;
            default:
            begin
                // TX counters sit at one word per port from the base offset
                for (int p = 0; p < NUM_PORTS; p++)
                begin
                    if (paddr == REG_TX_CNT_BASE + 8'(4 * p))
                        prdata = tx_cnt[p];
                end
            end
        endcase
    end

    // The APB master only raises penable inside a selected transfer
    a_penable_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

endmodule

`default_nettype wire

// File: hdl/tlp_fifo.sv
/*
 * Valid/ready FIFO with a type-parameterized payload, built as a
 * circular buffer with an occupancy count
 */
`default_nettype none

module tlp_fifo
  #(
    parameter int FIFO_DEPTH = 4,
    parameter type t_payload = logic
    )
   (
    input  wire      clk,
    input  wire      reset,

    input  wire      in_valid,
    output logic     in_ready,
    input  wire      t_payload in_data,

    output logic     out_valid,
    input  wire      out_ready,
    output t_payload out_data
    );

    // Depth is a power of two, so the pointers wrap on their own
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    t_payload mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic push;
    logic pop;

    assign in_ready = (count != (PTR_W + 1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    // Storage is written without reset, the count decides what is live
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            // Simultaneous push and pop leaves the occupancy unchanged
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // A full FIFO that is not drained keeps its write pointer and its count
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        ((count == (PTR_W + 1)'(FIFO_DEPTH)) && !pop) |=>
        ((count == (PTR_W + 1)'(FIFO_DEPTH)) && $stable(wr_ptr)));

    // The head stays put while the consumer stalls it
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

`default_nettype wire

// File: hdl/host_chan_ctrl_if.sv
/*
 * Control bundle between the register block and the datapath:
 * port enables out of the registers, packet events back into them
 */
`default_nettype none

interface host_chan_ctrl_if
  #(
    parameter int NUM_PORTS = 4
    );

    // Index width, kept at one bit for a single-port build
    localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    // One enable bit per accelerator port
    logic [NUM_PORTS-1:0] port_en;

    // Pulse on the last beat of a transmitted packet and the port it came from
    logic                 tx_eop;
    logic [PORT_W-1:0]    tx_port;

    // Pulse on the last beat of a discarded host packet
    logic                 rx_drop;

    modport regs (output port_en, input tx_eop, input tx_port, input rx_drop);
    modport tx (input port_en, output tx_eop, output tx_port);
    modport rx (input port_en, output rx_drop);

endinterface

`default_nettype wire

// File: hdl/host_chan_pkg.sv
/*
 * Shared definitions for the emulated host channel: beat widths,
 * the accelerator-side and host-side beat structs, and the APB
 * register offsets of the management block
 */
`default_nettype none

package host_chan_pkg;

    // Width of one TLP data beat
    localparam int DATA_WIDTH = 32;

    // Function number width, which caps the design at 16 ports
    localparam int FUNC_WIDTH = 4;

    // Beat as seen by an accelerator port
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  sop;
        logic                  eop;
    } t_afu_beat;

    // Beat on the shared host stream, tagged with the owning function
    typedef struct packed {
        logic [FUNC_WIDTH-1:0] func_num;
        t_afu_beat             beat;
    } t_tlp_beat;

    // Management register map
    localparam logic [7:0] REG_CTRL        = 8'h00;
    localparam logic [7:0] REG_PWR         = 8'h04;
    localparam logic [7:0] REG_PORT_EN     = 8'h08;
    localparam logic [7:0] REG_RX_DROP     = 8'h0C;
    localparam logic [7:0] REG_TX_CNT_BASE = 8'h10;

endpackage

`default_nettype wire
